// ==== Bender.yml ====
package:
  name: texLod

sources:
  - verilog/texPkg.sv
  - verilog/texConfIf.sv
  - verilog/texStageIf.sv
  - verilog/texSampleCtrl.sv
  - verilog/lodCalculator.sv
  - verilog/mipAddressGen.sv
  - verilog/texLodTop.sv
  - target: test
    files:
      - test/texLodTb.sv

// ==== list.f ====
verilog/texPkg.sv
verilog/texConfIf.sv
verilog/texStageIf.sv
verilog/texSampleCtrl.sv
verilog/lodCalculator.sv
verilog/mipAddressGen.sv
verilog/texLodTop.sv
test/texLodTb.sv

// ==== test/texLodTb.sv ====
// ********************************************************************
// Texture LOD testbench
// Table rows, back-pressure, config change and a random stream
// ********************************************************************
`timescale 1ns/1ps

module texLodTb;

    typedef struct packed {
        logic             mip;
        texPkg::sizeLog2T w;
        texPkg::sizeLog2T h;
        texPkg::texAddrT  base;
        texPkg::coordT    s;
        texPkg::coordT    t;
        texPkg::coordT    sxy;
        texPkg::coordT    txy;
        texPkg::fragTagT  tag;
        texPkg::lodT      lod;
        texPkg::texAddrT  addr;
    } rowT;

    logic aclk, rstN, sValid, sReady, confWrite, confMipEnable, mValid, mReady;
    texPkg::fragTagT tagIn, mTag;
    texPkg::coordT sS, sT, sSxy, sTxy;
    texPkg::sizeLog2T confWidthLog2, confHeightLog2;
    texPkg::texAddrT confBaseAddr, mAddr;
    texPkg::lodT mLod;

    // Model copy of the live configuration
    logic cfgMip;
    texPkg::sizeLog2T cfgW, cfgH;
    texPkg::texAddrT cfgBase;
    texPkg::lodT expLodQ[$];
    texPkg::texAddrT expAddrQ[$];
    texPkg::fragTagT expTagQ[$];
    integer seed = 15;
    rowT vectors[12];

    texLodTop #(.tagT(texPkg::fragTagT)) UUT (
        .aclk(aclk), .rstN(rstN), .sValid(sValid), .sTag(tagIn), .sS(sS), .sT(sT),
        .sSxy(sSxy), .sTxy(sTxy), .sReady(sReady), .confWrite(confWrite),
        .confMipEnable(confMipEnable), .confWidthLog2(confWidthLog2),
        .confHeightLog2(confHeightLog2), .confBaseAddr(confBaseAddr),
        .mValid(mValid), .mTag(mTag), .mLod(mLod), .mAddr(mAddr), .mReady(mReady)
    );

    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    task automatic reportFail(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic checkLod(input texPkg::lodT got, input texPkg::lodT exp);
        if (got !== exp)
            reportFail($sformatf("LOD got %0d expected %0d", got, exp));
    endtask

    task automatic checkAddr(input texPkg::texAddrT got, input texPkg::texAddrT exp);
        if (got !== exp)
            reportFail($sformatf("address got %0d expected %0d", got, exp));
    endtask

    task automatic checkTag(input texPkg::fragTagT got, input texPkg::fragTagT exp);
        if (got !== exp)
            reportFail($sformatf("tag got %0h expected %0h", got, exp));
    endtask

    // Expected result from the LOD and addressing rules
    task automatic pushExpected(input texPkg::fragTagT tag, input texPkg::coordT s,
                                input texPkg::coordT t, input texPkg::coordT sxy,
                                input texPkg::coordT txy);
        texPkg::coordT dS;
        texPkg::coordT dT;
        logic [14:0] aS;
        logic [14:0] aT;
        logic [7:0] texels;
        texPkg::lodT lod;
        texPkg::sizeLog2T maxS;
        texPkg::sizeLog2T lw;
        texPkg::sizeLog2T lh;
        texPkg::texAddrT col;
        texPkg::texAddrT row;
        dS = s - sxy;
        dT = t - txy;
        aS = (dS < 0) ? 15'(-dS) : 15'(dS);
        aT = (dT < 0) ? 15'(-dT) : 15'(dT);
        texels = 8'((aS >> (15 - cfgW)) | (aT >> (15 - cfgH)));
        lod = '0;
        for (int i = 0; i < 8; i++)
            if (texels[i])
                lod = texPkg::lodT'(i + 1);
        if (!cfgMip)
            lod = '0;
        maxS = (cfgW > cfgH) ? cfgW : cfgH;
        if (lod > maxS)
            lod = maxS;
        lw = (cfgW > lod) ? cfgW - lod : '0;
        lh = (cfgH > lod) ? cfgH - lod : '0;
        col = texPkg::texAddrT'(s[14:0] >> (15 - lw));
        row = texPkg::texAddrT'(t[14:0] >> (15 - lh));
        expLodQ.push_back(lod);
        expTagQ.push_back(tag);
        expAddrQ.push_back(cfgBase + texPkg::levelOffset(cfgW, cfgH, lod) + (row << lw) + col);
    endtask

    // Check outputs at the falling edge and then drive the next inputs
    task automatic stepCycle(input logic v, input texPkg::fragTagT tag,
                             input texPkg::coordT s, input texPkg::coordT t,
                             input texPkg::coordT sxy, input texPkg::coordT txy,
                             input logic rdy, input logic wr);
        @(negedge aclk);
        // sReady has had half a cycle to follow the last mReady
        if (sReady !== mReady)
            reportFail("sReady does not follow mReady");
        if (mValid && rdy)
        begin
            if (expTagQ.size() == 0)
                reportFail("result appeared with nothing expected");
            else
            begin
                checkTag(mTag, expTagQ.pop_front());
                checkLod(mLod, expLodQ.pop_front());
                checkAddr(mAddr, expAddrQ.pop_front());
            end
        end
        // Accepted on the coming edge with the config before any write
        if (v && rdy)
            pushExpected(tag, s, t, sxy, txy);
        if (wr)
        begin
            cfgMip  = confMipEnable;
            cfgW    = (confWidthLog2 > 8) ? 4'd8 : confWidthLog2;
            cfgH    = (confHeightLog2 > 8) ? 4'd8 : confHeightLog2;
            cfgBase = confBaseAddr;
        end
        sValid = v;
        tagIn = tag;
        sS = s;
        sT = t;
        sSxy = sxy;
        sTxy = txy;
        mReady = rdy;
        confWrite = wr;
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        while (expTagQ.size() != 0 && cnt < 20)
        begin
            stepCycle(1'b0, '0, 0, 0, 0, 0, 1'b1, 1'b0);
            cnt++;
        end
        if (expTagQ.size() != 0)
        begin
            $display("Timeout at %0d ns: no result arrived", $time);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic setConf(input logic mip, input texPkg::sizeLog2T w,
                           input texPkg::sizeLog2T h, input texPkg::texAddrT base);
        confMipEnable = mip;
        confWidthLog2 = w;
        confHeightLog2 = h;
        confBaseAddr = base;
        stepCycle(1'b0, '0, 0, 0, 0, 0, 1'b1, 1'b1);
    endtask

    initial
    begin
        texPkg::fragTagT holdTag;
        texPkg::texAddrT holdAddr;
        texPkg::lodT holdLod;
        int sent;
        logic v;
        logic rdy;
        texPkg::coordT rs;
        texPkg::coordT rt;
        // Expected LOD and address worked out by hand
        vectors[0]  = '{0, 8, 8, 20'h100, 1280, 384, 26880, 384, 8'h10, 0, 1034};
        vectors[1]  = '{1, 8, 8, 0, 0, 0, 0, 0, 8'h11, 0, 0};
        vectors[2]  = '{1, 8, 8, 0, 0, 0, 128, 0, 8'h12, 1, 65536};
        vectors[3]  = '{1, 8, 8, 0, 0, 0, 0, 384, 8'h13, 2, 81920};
        vectors[4]  = '{1, 8, 8, 0, 0, 0, -512, 0, 8'h14, 3, 86016};
        vectors[5]  = '{1, 8, 8, 0, 0, 0, 0, 25600, 8'h15, 8, 87380};
        vectors[6]  = '{1, 8, 8, 0, 16384, 8192, 16512, 8192, 8'h16, 1, 69696};
        vectors[7]  = '{1, 8, 4, 0, 0, 0, 128, 6144, 8'h17, 2, 5120};
        vectors[8]  = '{0, 8, 8, 0, -32128, 66432, -32128, 66432, 8'h18, 0, 1797};
        vectors[9]  = '{1, 3, 1, 0, 24576, 16384, 36864, 16384, 8'h19, 2, 21};
        vectors[10] = '{1, 3, 1, 20'h40, 0, 0, 28672, 0, 8'h1A, 3, 86};
        vectors[11] = '{1, 8, 8, 0, 0, 0, 25600, 128, 8'h1B, 8, 87380};
        rstN = 1'b0;
        sValid = 1'b0;
        tagIn = '0;
        sS = 0;
        sT = 0;
        sSxy = 0;
        sTxy = 0;
        confWrite = 1'b0;
        confMipEnable = 1'b0;
        confWidthLog2 = '0;
        confHeightLog2 = '0;
        confBaseAddr = '0;
        mReady = 1'b1;
        cfgMip = 1'b0;
        cfgW = '0;
        cfgH = '0;
        cfgBase = '0;
        repeat (3) @(negedge aclk);
        rstN = 1'b1;
        if (mValid !== 1'b0)
            reportFail("mValid high after reset");
        // Hand computed rows checked against the model
        foreach (vectors[i])
        begin
            setConf(vectors[i].mip, vectors[i].w, vectors[i].h, vectors[i].base);
            stepCycle(1'b1, vectors[i].tag, vectors[i].s, vectors[i].t, vectors[i].sxy,
                      vectors[i].txy, 1'b1, 1'b0);
            checkLod(expLodQ[0], vectors[i].lod);
            checkAddr(expAddrQ[0], vectors[i].addr);
            drain();
        end
        // Back-pressure with two fragments in flight
        setConf(1'b1, 4'd8, 4'd8, 20'h300);
        stepCycle(1'b1, 8'h21, 640, 384, 1152, 0, 1'b1, 1'b0);
        stepCycle(1'b1, 8'h22, 16384, 8192, 16384, 9000, 1'b1, 1'b0);
        for (int i = 0; i < 6; i++)
        begin
            stepCycle(1'b1, 8'hEE, 0, 0, 0, 0, 1'b0, 1'b0);
            if (i == 0)
            begin
                holdTag = mTag;
                holdLod = mLod;
                holdAddr = mAddr;
            end
            else if (mValid !== 1'b1 || mTag !== holdTag || mLod !== holdLod
                     || mAddr !== holdAddr)
                reportFail("outputs changed under back-pressure");
        end
        drain();
        // Config write between two fragments
        setConf(1'b0, 4'd8, 4'd8, 20'h0);
        stepCycle(1'b1, 8'h31, 640, 1280, 640, 1280, 1'b1, 1'b0);
        confWidthLog2 = 4'd4;
        confHeightLog2 = 4'd4;
        confBaseAddr = 20'h200;
        stepCycle(1'b0, '0, 0, 0, 0, 0, 1'b1, 1'b1);
        stepCycle(1'b1, 8'h32, 640, 1280, 640, 1280, 1'b1, 1'b0);
        drain();
        // Random stream with random sink gaps
        setConf(1'b1, 4'($random(seed)), 4'($random(seed)), 20'($random(seed)));
        sent = 0;
        while (sent < 200)
        begin
            v = 1'($random(seed));
            rdy = ($random(seed) % 4) != 0;
            rs = $random(seed);
            rt = $random(seed);
            stepCycle(v, texPkg::fragTagT'(sent), rs, rt, rs + ($random(seed) % 32768),
                      rt + ($random(seed) % 32768), rdy, 1'b0);
            if (v && rdy)
                sent++;
        end
        drain();
        $display("TESTBENCH PASSED");
        $finish;
    end

    // Overall guard against a stuck run
    initial
    begin
        #2000000;
        $display("Timeout: simulation did not finish");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

// ==== verilog/lodCalculator.sv ====
// ********************************************************************
// LOD calculator
// First stage, LOD from the diagonal neighbour coordinate difference
// ********************************************************************
`timescale 1ns/1ps

module lodCalculator #(
    parameter type tagT = texPkg::fragTagT
) (
    input  logic            aclk,
    input  logic            rstN,
    texConfIf.stage         conf,
    input  logic            sValid,
    input  tagT             sTag,
    input  texPkg::coordT   sS,
    input  texPkg::coordT   sT,
    input  texPkg::coordT   sSxy,
    input  texPkg::coordT   sTxy,
    texStageIf.src          out
);

    texPkg::coordT diffS;
    texPkg::coordT diffT;
    logic [14:0]   absS;
    logic [14:0]   absT;
    logic [7:0]    texelsU;
    logic [7:0]    texelsV;
    logic [7:0]    diffMax;
    texPkg::lodT   lodNext;

    // Neighbour sits one pixel right and down in screen space
    assign diffS = sS - sSxy;
    assign diffT = sT - sTxy;

    // Magnitude within one repeat, sign taken from the full difference
    assign absS = diffS[31] ? 15'(-diffS[14:0]) : diffS[14:0];
    assign absT = diffT[31] ? 15'(-diffT[14:0]) : diffT[14:0];

    // Top 8 fraction bits scaled down to level-0 texels per axis
    assign texelsU = absS[14:7] >> (4'd8 - conf.widthLog2);
    assign texelsV = absT[14:7] >> (4'd8 - conf.heightLog2);

    // Either axis can dominate
    assign diffMax = texelsU | texelsV;

    // Highest set bit, counted from 1
    always_comb
    begin
        lodNext = '0;
        for (int i = 0; i < texPkg::MaxLod; i++)
        begin
            if (diffMax[i])
                lodNext = texPkg::lodT'(i + 1);
        end
        // No mipmapping means always level 0
        if (!conf.mipEnable)
            lodNext = '0;
    end

    // Stage valid
    always_ff @(posedge aclk)
    begin
        if (!rstN)
            out.valid <= 1'b0;
        else if (conf.ce)
            out.valid <= sValid;
    end

    // Stage payload, held while ce is low
    always_ff @(posedge aclk)
    begin
        if (conf.ce)
        begin
            out.tag <= sTag;
            out.lod <= lodNext;
            out.s   <= sS;
            out.t   <= sT;
        end
    end

endmodule

// ==== verilog/mipAddressGen.sv ====
// ********************************************************************
// Mip address generator
// Second stage, clamps the LOD and forms the wrapped texel address
// ********************************************************************
`timescale 1ns/1ps

module mipAddressGen #(
    parameter type tagT = texPkg::fragTagT
) (
    input  logic              aclk,
    input  logic              rstN,
    texConfIf.stage           conf,
    texStageIf.dst            in,
    output logic              mValid,
    output tagT               mTag,
    output texPkg::lodT       mLod,
    output texPkg::texAddrT   mAddr
);

    texPkg::sizeLog2T maxSize;
    texPkg::lodT      lodClamp;
    texPkg::sizeLog2T levelW;
    texPkg::sizeLog2T levelH;
    logic [14:0]      colFull;
    logic [14:0]      rowFull;
    logic [7:0]       col;
    logic [7:0]       row;
    texPkg::texAddrT  rowBase;
    texPkg::texAddrT  addrNext;

    // Chain ends where the larger axis reaches one texel
    assign maxSize  = (conf.widthLog2 > conf.heightLog2) ? conf.widthLog2 : conf.heightLog2;
    assign lodClamp = (in.lod > maxSize) ? maxSize : in.lod;

    // Level dimensions, never below one texel
    assign levelW = (conf.widthLog2 > lodClamp) ? conf.widthLog2 - lodClamp : '0;
    assign levelH = (conf.heightLog2 > lodClamp) ? conf.heightLog2 - lodClamp : '0;

    // Fraction bits only, so integer part and sign wrap away
    assign colFull = in.s[14:0] >> (4'd15 - levelW);
    assign rowFull = in.t[14:0] >> (4'd15 - levelH);

    // At most 256 texels per side
    assign col = colFull[7:0];
    assign row = rowFull[7:0];

    // Row start inside the level
    assign rowBase = texPkg::texAddrT'(row) << levelW;

    // Base, then skip the larger levels, then the texel itself
    assign addrNext = conf.baseAddr
                    + texPkg::levelOffset(conf.widthLog2, conf.heightLog2, lodClamp)
                    + rowBase
                    + texPkg::texAddrT'(col);

    // Output valid
    always_ff @(posedge aclk)
    begin
        if (!rstN)
            mValid <= 1'b0;
        else if (conf.ce)
            mValid <= in.valid;
    end

    // Result payload
    // Stable under back-pressure
    always_ff @(posedge aclk)
    begin
        if (conf.ce)
        begin
            mTag  <= in.tag;
            mLod  <= lodClamp;
            mAddr <= addrNext;
        end
    end

endmodule

// ==== verilog/texConfIf.sv ====
// ********************************************************************
// Texture configuration bus
// Latched configuration and pipeline enable from control to stages
// ********************************************************************
`timescale 1ns/1ps

interface texConfIf;

    // Mip mapping on, LOD forced to 0 otherwise
    logic mipEnable;

    // Level-0 texture size as log2
    texPkg::sizeLog2T widthLog2;
    texPkg::sizeLog2T heightLog2;

    // Start of the mip chain in texel words
    texPkg::texAddrT baseAddr;

    // Pipeline clock enable, all stages advance together
    logic ce;

    // Control side drives everything
    modport ctrl (
        output mipEnable, widthLog2, heightLog2, baseAddr, ce
    );

    // Datapath stages only read
    modport stage (
        input mipEnable, widthLog2, heightLog2, baseAddr, ce
    );

endinterface

// ==== verilog/texLodTop.sv ====
// ********************************************************************
// Texture LOD and address top level
// Control plus the two stage mip address pipeline
// ********************************************************************
`timescale 1ns/1ps

module texLodTop #(
    parameter type tagT = texPkg::fragTagT
) (
    input  logic              aclk,
    input  logic              rstN,
    // Fragment input
    input  logic              sValid,
    input  tagT               sTag,
    input  texPkg::coordT     sS,
    input  texPkg::coordT     sT,
    input  texPkg::coordT     sSxy,
    input  texPkg::coordT     sTxy,
    output logic              sReady,
    // Configuration write
    input  logic              confWrite,
    input  logic              confMipEnable,
    input  texPkg::sizeLog2T  confWidthLog2,
    input  texPkg::sizeLog2T  confHeightLog2,
    input  texPkg::texAddrT   confBaseAddr,
    // Result output
    output logic              mValid,
    output tagT               mTag,
    output texPkg::lodT       mLod,
    output texPkg::texAddrT   mAddr,
    input  logic              mReady
);

    texConfIf confBus ();
    texStageIf #(.tagT(tagT)) stageBus ();

    // Config registers and pipeline enable
    texSampleCtrl ctrl (
        .aclk(aclk), .rstN(rstN),
        .confWrite(confWrite), .confMipEnable(confMipEnable),
        .confWidthLog2(confWidthLog2), .confHeightLog2(confHeightLog2),
        .confBaseAddr(confBaseAddr),
        .mReady(mReady), .sReady(sReady), .conf(confBus.ctrl)
    );

    // Stage 1
    lodCalculator #(.tagT(tagT)) lodCalc (
        .aclk(aclk), .rstN(rstN), .conf(confBus.stage),
        .sValid(sValid), .sTag(sTag),
        .sS(sS), .sT(sT), .sSxy(sSxy), .sTxy(sTxy),
        .out(stageBus.src)
    );

    // Stage 2
    mipAddressGen #(.tagT(tagT)) addrGen (
        .aclk(aclk), .rstN(rstN), .conf(confBus.stage), .in(stageBus.dst),
        .mValid(mValid), .mTag(mTag), .mLod(mLod), .mAddr(mAddr)
    );

endmodule

// ==== verilog/texPkg.sv ====
// ********************************************************************
// Texture LOD package
// Shared fixed-point, tag, LOD and address types plus the mip chain
// level-offset helper
// ********************************************************************
package texPkg;

    // S16.15 texture coordinate, bits 14..0 are the fraction in one repeat
    typedef logic signed [31:0] coordT;

    // Texture dimension as log2, legal range 0..8
    typedef logic [3:0] sizeLog2T;

    // Mip level, 0..8
    typedef logic [3:0] lodT;

    // Texel word address
    typedef logic [19:0] texAddrT;

    // Default user tag carried with each fragment
    typedef logic [7:0] fragTagT;

    // Deepest level the calculator reports (256 texel textures)
    localparam int MaxLod = 8;

    // Texel count of all levels stored above the given level
    function automatic texAddrT levelOffset(
        input sizeLog2T widthLog2,
        input sizeLog2T heightLog2,
        input lodT      level
    );
        texAddrT  offset;
        sizeLog2T levelW;
        sizeLog2T levelH;
        offset = '0;
        for (int i = 0; i < MaxLod; i++)
        begin
            // Each level halves per axis but keeps at least one texel
            levelW = (widthLog2 > i) ? sizeLog2T'(widthLog2 - i) : '0;
            levelH = (heightLog2 > i) ? sizeLog2T'(heightLog2 - i) : '0;
            if (i < level)
                offset = offset + (texAddrT'(1) << ({1'b0, levelW} + {1'b0, levelH}));
        end
        return offset;
    endfunction

endpackage

// ==== verilog/texSampleCtrl.sv ====
// ********************************************************************
// Texture sampler control
// Configuration register bank and pipeline enable
// ********************************************************************
`timescale 1ns/1ps

module texSampleCtrl (
    input  logic               aclk,
    input  logic               rstN,
    input  logic               confWrite,
    input  logic               confMipEnable,
    input  texPkg::sizeLog2T   confWidthLog2,
    input  texPkg::sizeLog2T   confHeightLog2,
    input  texPkg::texAddrT    confBaseAddr,
    input  logic               mReady,
    output logic               sReady,
    texConfIf.ctrl             conf
);

    // Largest legal size, a 256 texel side
    localparam texPkg::sizeLog2T MaxSize = texPkg::sizeLog2T'(texPkg::MaxLod);

    texPkg::sizeLog2T widthSat;
    texPkg::sizeLog2T heightSat;

    // Saturate out of range sizes on the way in
    assign widthSat  = (confWidthLog2 > MaxSize) ? MaxSize : confWidthLog2;
    assign heightSat = (confHeightLog2 > MaxSize) ? MaxSize : confHeightLog2;

    // Configuration registers
    // All four fields load together on the strobe
    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            conf.mipEnable  <= 1'b0;
            conf.widthLog2  <= '0;
            conf.heightLog2 <= '0;
            conf.baseAddr   <= '0;
        end
        else if (confWrite)
        begin
            conf.mipEnable  <= confMipEnable;
            conf.widthLog2  <= widthSat;
            conf.heightLog2 <= heightSat;
            conf.baseAddr   <= confBaseAddr;
        end
    end

    // Whole pipeline moves only while the sink takes data
    assign conf.ce = mReady;

    // Input side ready follows the output side directly
    assign sReady = mReady;

endmodule

// ==== verilog/texStageIf.sv ====
// ********************************************************************
// Texture stage bus
// One fragment with its LOD between the LOD and address stages
// ********************************************************************
`timescale 1ns/1ps

interface texStageIf #(
    parameter type tagT = texPkg::fragTagT
);

    // Fragment present, low for a bubble
    logic valid;

    // Opaque user payload
    tagT tag;

    // Unclamped LOD from the calculator
    texPkg::lodT lod;

    // Coordinates forwarded for addressing
    texPkg::coordT s;
    texPkg::coordT t;

    modport src (output valid, tag, lod, s, t);

    modport dst (input valid, tag, lod, s, t);

endinterface
